// File: design/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// datapath and ROB sizing
`define DEC_XLEN        32
`define DEC_ROB_DEPTH   16
`define DEC_ROB_W       4      // log2 of the ROB depth
`define DEC_NREGS       32
`define DEC_REG_W       5
`define DEC_IMM_W       16

// major opcodes in insn[31:26]
`define DEC_OPC_SPECIAL 6'h00
`define DEC_OPC_ADDIU   6'h09
`define DEC_OPC_LW      6'h23
`define DEC_OPC_SW      6'h2b
`define DEC_OPC_BEQ     6'h04
`define DEC_OPC_BNE     6'h05

// function codes in insn[5:0] under SPECIAL
`define DEC_FN_ADDU     6'h21
`define DEC_FN_SUBU     6'h23
`define DEC_FN_AND      6'h24
`define DEC_FN_OR       6'h25
`define DEC_FN_SLT      6'h2a

`endif

// File: design/decode_pkg.sv
`include "decode_defs.svh"

package decode_pkg;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_SLT,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_NONE
    } op_e;

    typedef enum logic [1:0] {
        PIPE_NONE,
        PIPE_ALU,
        PIPE_MEM,
        PIPE_BRU
    } pipe_e;

    // ------------------------------
    typedef struct packed {
        logic [`DEC_XLEN-1:0]   pc;
        logic [31:0]            insn;
    } fetch_t;

    typedef struct packed {
        logic [`DEC_XLEN-1:0]   pc;
        pipe_e                  pipe;
        op_e                    op;
        logic [`DEC_REG_W-1:0]  src0;
        logic [`DEC_REG_W-1:0]  src1;
        logic [`DEC_REG_W-1:0]  dst;     // zero when nothing is written
        logic [`DEC_XLEN-1:0]   imm;
        logic                   load;
        logic                   store;
    } uop_t;

    typedef struct packed {
        logic [`DEC_ROB_W-1:0]  rob;
        logic [`DEC_XLEN-1:0]   value;
    } wb_t;

    typedef struct packed {
        logic [`DEC_ROB_W-1:0]  rob;
        logic [`DEC_XLEN-1:0]   pc;
        logic [`DEC_REG_W-1:0]  dst;
        logic [`DEC_XLEN-1:0]   value;
        logic                   load;
        logic                   store;
    } commit_t;

    // a source that is not ready waits on the tag in src*_rob
    typedef struct packed {
        uop_t                   uop;
        logic [`DEC_ROB_W-1:0]  dst_rob;
        logic [`DEC_ROB_W-1:0]  src0_rob;
        logic                   src0_ready;
        logic [`DEC_XLEN-1:0]   src0_value;
        logic [`DEC_ROB_W-1:0]  src1_rob;
        logic                   src1_ready;
        logic [`DEC_XLEN-1:0]   src1_value;
    } issue_t;

endpackage

// File: design/decode_ctrl.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module decode_ctrl (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_if_valid,
    input  logic                  i_issue_readyn,
    input  logic                  i_commit_en,
    output logic                  o_if_readyn,
    output logic                  o_fetch_en,
    output logic                  o_alloc_en,
    output logic                  o_issue_valid,
    output logic [`DEC_ROB_W-1:0] o_alloc_rob,
    output logic [`DEC_ROB_W-1:0] o_head_rob
);

    logic                  fetch_v;    // word sitting in the fetch register
    logic                  uop_v;      // word sitting in the uop register
    logic [`DEC_ROB_W-1:0] tail;
    logic [`DEC_ROB_W-1:0] head;
    logic [`DEC_ROB_W:0]   count;
    logic [`DEC_ROB_W:0]   free_cnt;
    logic [`DEC_ROB_W:0]   in_flight;

    // ------------------------------
    // fetch back-pressure
    assign free_cnt  = (`DEC_ROB_W+1)'(`DEC_ROB_DEPTH) - count;
    assign in_flight = (`DEC_ROB_W+1)'(fetch_v) + (`DEC_ROB_W+1)'(uop_v);

    // the next word must still find an entry after the two ahead of it
    assign o_if_readyn = i_issue_readyn || (free_cnt <= in_flight);
    assign o_fetch_en  = i_if_valid && !o_if_readyn;

    assign o_alloc_en  = uop_v;
    assign o_alloc_rob = tail;
    assign o_head_rob  = head;

    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            fetch_v       <= 1'b0;
            uop_v         <= 1'b0;
            o_issue_valid <= 1'b0;
            tail          <= '0;
            head          <= '0;
            count         <= '0;
        end else begin
            fetch_v       <= o_fetch_en;
            uop_v         <= fetch_v;
            o_issue_valid <= uop_v;    // issue record is loaded on the alloc edge
            if (o_alloc_en) begin
                tail <= tail + 1'b1;
            end
            if (i_commit_en) begin
                head <= head + 1'b1;
            end
            if (o_alloc_en && !i_commit_en) begin
                count <= count + 1'b1;
            end else if (!o_alloc_en && i_commit_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // ------------------------------
    a_occ_bound: assert property (
        @(posedge i_clk) disable iff (i_reset)
        count <= (`DEC_ROB_W+1)'(`DEC_ROB_DEPTH)
    );

    // no entry is allocated while the ROB is full
    a_alloc_not_full: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_alloc_en |-> (count != (`DEC_ROB_W+1)'(`DEC_ROB_DEPTH))
    );

endmodule

// File: design/decode_insn.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module decode_insn (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_fetch_en,
    input  decode_pkg::fetch_t i_if,
    output decode_pkg::uop_t   o_uop
);

    import decode_pkg::*;

    fetch_t    if_q;
    uop_t      dec;
    logic [5:0] opc;
    logic [5:0] fn;

    assign opc = if_q.insn[31:26];
    assign fn  = if_q.insn[5:0];

    // ------------------------------
    always_comb begin
        dec       = '0;
        dec.pc    = if_q.pc;
        dec.pipe  = PIPE_NONE;
        dec.op    = OP_NONE;
        dec.imm   = {{(`DEC_XLEN-`DEC_IMM_W){if_q.insn[15]}}, if_q.insn[15:0]};
        case (opc)
            `DEC_OPC_SPECIAL: begin
                dec.pipe = PIPE_ALU;
                dec.src0 = if_q.insn[25:21];
                dec.src1 = if_q.insn[20:16];
                dec.dst  = if_q.insn[15:11];
                case (fn)
                    `DEC_FN_ADDU: dec.op = OP_ADD;
                    `DEC_FN_SUBU: dec.op = OP_SUB;
                    `DEC_FN_AND:  dec.op = OP_AND;
                    `DEC_FN_OR:   dec.op = OP_OR;
                    `DEC_FN_SLT:  dec.op = OP_SLT;
                    default: begin
                        dec.pipe = PIPE_NONE;    // unknown function issues as a bubble
                        dec.src0 = '0;
                        dec.src1 = '0;
                        dec.dst  = '0;
                    end
                endcase
            end
            `DEC_OPC_ADDIU, `DEC_OPC_LW: begin
                dec.pipe = (opc == `DEC_OPC_LW) ? PIPE_MEM : PIPE_ALU;
                dec.op   = (opc == `DEC_OPC_LW) ? OP_LW : OP_ADD;
                dec.load = (opc == `DEC_OPC_LW);
                dec.src0 = if_q.insn[25:21];
                dec.dst  = if_q.insn[20:16];
            end
            `DEC_OPC_SW, `DEC_OPC_BEQ, `DEC_OPC_BNE: begin
                dec.src0  = if_q.insn[25:21];
                dec.src1  = if_q.insn[20:16];
                dec.store = (opc == `DEC_OPC_SW);
                dec.pipe  = (opc == `DEC_OPC_SW) ? PIPE_MEM : PIPE_BRU;
                dec.op    = (opc == `DEC_OPC_SW) ? OP_SW
                          : (opc == `DEC_OPC_BEQ) ? OP_BEQ : OP_BNE;
            end
            default: ;
        endcase
    end

    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            if_q  <= '0;
            o_uop <= '0;
        end else begin
            if (i_fetch_en) begin
                if_q <= i_if;
            end
            o_uop <= dec;    // the valid bit follows in decode_ctrl
        end
    end

endmodule

// File: design/decode_rob.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module decode_rob (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_alloc_en,
    input  logic [`DEC_ROB_W-1:0] i_alloc_rob,
    input  logic [`DEC_ROB_W-1:0] i_head_rob,
    input  decode_pkg::uop_t      i_uop,
    input  logic                  i_wb_en,
    input  decode_pkg::wb_t       i_wb,
    input  logic                  i_commit_en,
    input  logic [`DEC_ROB_W-1:0] i_src0_rob,
    input  logic [`DEC_ROB_W-1:0] i_src1_rob,
    output logic                  o_src0_done,
    output logic                  o_src1_done,
    output logic [`DEC_XLEN-1:0]  o_src0_value,
    output logic [`DEC_XLEN-1:0]  o_src1_value,
    output logic                  o_commit_valid,
    output logic                  o_commit_ready,
    output decode_pkg::commit_t   o_commit
);

    import decode_pkg::*;

    logic [`DEC_XLEN-1:0]      pc_mem    [`DEC_ROB_DEPTH];
    logic [`DEC_REG_W-1:0]     dst_mem   [`DEC_ROB_DEPTH];
    logic [`DEC_XLEN-1:0]      value_mem [`DEC_ROB_DEPTH];
    logic [`DEC_ROB_DEPTH-1:0] ld_mem;
    logic [`DEC_ROB_DEPTH-1:0] st_mem;
    logic [`DEC_ROB_DEPTH-1:0] occ;
    logic [`DEC_ROB_DEPTH-1:0] done;
    logic                      wb_hit0;
    logic                      wb_hit1;

    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_alloc_en) begin
            pc_mem[i_alloc_rob]  <= i_uop.pc;
            dst_mem[i_alloc_rob] <= i_uop.dst;
            ld_mem[i_alloc_rob]  <= i_uop.load;
            st_mem[i_alloc_rob]  <= i_uop.store;
        end
        if (i_wb_en) begin
            value_mem[i_wb.rob] <= i_wb.value;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            occ  <= '0;
            done <= '0;
        end else begin
            if (i_commit_en) begin
                occ[i_head_rob] <= 1'b0;
            end
            if (i_alloc_en) begin
                occ[i_alloc_rob]  <= 1'b1;
                done[i_alloc_rob] <= 1'b0;
            end
            if (i_wb_en) begin
                done[i_wb.rob] <= 1'b1;
            end
        end
    end

    // ------------------------------
    // source reads see a writeback landing in the same cycle
    assign wb_hit0      = i_wb_en && (i_wb.rob == i_src0_rob);
    assign wb_hit1      = i_wb_en && (i_wb.rob == i_src1_rob);
    assign o_src0_done  = done[i_src0_rob] || wb_hit0;
    assign o_src1_done  = done[i_src1_rob] || wb_hit1;
    assign o_src0_value = wb_hit0 ? i_wb.value : value_mem[i_src0_rob];
    assign o_src1_value = wb_hit1 ? i_wb.value : value_mem[i_src1_rob];

    assign o_commit_valid = occ[i_head_rob];
    assign o_commit_ready = occ[i_head_rob] && done[i_head_rob];

    always_comb begin
        o_commit.rob   = i_head_rob;
        o_commit.pc    = pc_mem[i_head_rob];
        o_commit.dst   = dst_mem[i_head_rob];
        o_commit.value = value_mem[i_head_rob];
        o_commit.load  = ld_mem[i_head_rob];
        o_commit.store = st_mem[i_head_rob];
    end

    // ------------------------------
    a_wb_target: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_wb_en |-> (occ[i_wb.rob] && !done[i_wb.rob])
    );

    a_commit_done: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_commit_en |-> (occ[i_head_rob] && done[i_head_rob])
    );

endmodule

// File: design/decode_rename.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module decode_rename (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_alloc_en,
    input  logic [`DEC_ROB_W-1:0] i_alloc_rob,
    input  decode_pkg::uop_t      i_uop,
    input  logic                  i_commit_en,
    input  decode_pkg::commit_t   i_commit,
    output logic [`DEC_ROB_W-1:0] o_src0_rob,
    output logic [`DEC_ROB_W-1:0] o_src1_rob,
    input  logic                  i_src0_done,
    input  logic                  i_src1_done,
    input  logic [`DEC_XLEN-1:0]  i_src0_value,
    input  logic [`DEC_XLEN-1:0]  i_src1_value,
    output decode_pkg::issue_t    o_issue
);

    import decode_pkg::*;

    logic [`DEC_NREGS-1:0] pend;                      // register has an uncommitted producer
    logic [`DEC_ROB_W-1:0] prod_tag [`DEC_NREGS];
    logic [`DEC_XLEN-1:0]  rf       [`DEC_NREGS];
    logic                  src0_pend;
    logic                  src1_pend;
    logic                  src0_ready;
    logic                  src1_ready;
    logic [`DEC_XLEN-1:0]  src0_value;
    logic [`DEC_XLEN-1:0]  src1_value;
    logic                  alloc_dst;
    logic                  commit_dst;

    // ------------------------------
    // source lookup
    assign src0_pend  = pend[i_uop.src0];
    assign src1_pend  = pend[i_uop.src1];
    assign o_src0_rob = prod_tag[i_uop.src0];
    assign o_src1_rob = prod_tag[i_uop.src1];

    assign src0_ready = !src0_pend || i_src0_done;
    assign src1_ready = !src1_pend || i_src1_done;
    assign src0_value = src0_pend ? i_src0_value : rf[i_uop.src0];
    assign src1_value = src1_pend ? i_src1_value : rf[i_uop.src1];

    // register 0 never gets a producer and is never written
    assign alloc_dst  = i_alloc_en && (i_uop.dst != '0);
    assign commit_dst = i_commit_en && (i_commit.dst != '0);

    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (alloc_dst) begin
            prod_tag[i_uop.dst] <= i_alloc_rob;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pend <= '0;
            for (int r = 0; r < `DEC_NREGS; r++) begin
                rf[r] <= '0;
            end
        end else begin
            if (commit_dst) begin
                rf[i_commit.dst] <= i_commit.value;
                if (prod_tag[i_commit.dst] == i_commit.rob) begin
                    pend[i_commit.dst] <= 1'b0;    // a newer producer keeps it pending
                end
            end
            if (alloc_dst) begin
                pend[i_uop.dst] <= 1'b1;    // overrides a clear from the same edge
            end
        end
    end

    // ------------------------------
    // issue register
    always_ff @(posedge i_clk) begin
        if (i_alloc_en) begin
            o_issue.uop        <= i_uop;
            o_issue.dst_rob    <= i_alloc_rob;
            o_issue.src0_rob   <= o_src0_rob;
            o_issue.src0_ready <= src0_ready;
            o_issue.src0_value <= src0_value;
            o_issue.src1_rob   <= o_src1_rob;
            o_issue.src1_ready <= src1_ready;
            o_issue.src1_value <= src1_value;
        end
    end

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module decode_stage (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_if_valid,
    input  decode_pkg::fetch_t  i_if,
    output logic                o_if_readyn,
    input  logic                i_issue_readyn,
    output logic                o_issue_valid,
    output decode_pkg::issue_t  o_issue,
    input  logic                i_wb_en,
    input  decode_pkg::wb_t     i_wb,
    output logic                o_commit_valid,
    output logic                o_commit_ready,
    output decode_pkg::commit_t o_commit,
    input  logic                i_commit_en
);

    import decode_pkg::*;

    logic                  fetch_en;
    logic                  alloc_en;
    logic [`DEC_ROB_W-1:0] alloc_rob;
    logic [`DEC_ROB_W-1:0] head_rob;
    uop_t                  uop;
    logic [`DEC_ROB_W-1:0] src0_rob;
    logic [`DEC_ROB_W-1:0] src1_rob;
    logic                  src0_done;
    logic                  src1_done;
    logic [`DEC_XLEN-1:0]  src0_value;
    logic [`DEC_XLEN-1:0]  src1_value;

    // ------------------------------
    decode_ctrl ctrl_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_if_valid     (i_if_valid),
        .i_issue_readyn (i_issue_readyn),
        .i_commit_en    (i_commit_en),
        .o_if_readyn    (o_if_readyn),
        .o_fetch_en     (fetch_en),
        .o_alloc_en     (alloc_en),
        .o_issue_valid  (o_issue_valid),
        .o_alloc_rob    (alloc_rob),
        .o_head_rob     (head_rob)
    );

    decode_insn insn_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_fetch_en (fetch_en),
        .i_if       (i_if),
        .o_uop      (uop)
    );

    decode_rob rob_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_alloc_en     (alloc_en),
        .i_alloc_rob    (alloc_rob),
        .i_head_rob     (head_rob),
        .i_uop          (uop),
        .i_wb_en        (i_wb_en),
        .i_wb           (i_wb),
        .i_commit_en    (i_commit_en),
        .i_src0_rob     (src0_rob),
        .i_src1_rob     (src1_rob),
        .o_src0_done    (src0_done),
        .o_src1_done    (src1_done),
        .o_src0_value   (src0_value),
        .o_src1_value   (src1_value),
        .o_commit_valid (o_commit_valid),
        .o_commit_ready (o_commit_ready),
        .o_commit       (o_commit)
    );

    // the head entry also drives the register-file write
    decode_rename rename_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_alloc_en   (alloc_en),
        .i_alloc_rob  (alloc_rob),
        .i_uop        (uop),
        .i_commit_en  (i_commit_en),
        .i_commit     (o_commit),
        .o_src0_rob   (src0_rob),
        .o_src1_rob   (src1_rob),
        .i_src0_done  (src0_done),
        .i_src1_done  (src1_done),
        .i_src0_value (src0_value),
        .i_src1_value (src1_value),
        .o_issue      (o_issue)
    );

endmodule

// File: bench/decode_stage_tb.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module decode_stage_tb;

    import decode_pkg::*;

    logic clk;
    logic reset;
    logic if_valid;
    fetch_t if_word;
    logic if_readyn;
    logic issue_readyn;
    logic issue_valid;
    issue_t issue;
    logic wb_en;
    wb_t wb;
    logic commit_valid;
    logic commit_ready;
    commit_t commit;
    logic commit_en;

    integer seed;
    logic [`DEC_XLEN-1:0] pc_next;

    // reference state, all updated on the clock edge
    logic [2:0] pipe_v;                            // fetch, uop and issue slots
    fetch_t pipe_w [2];
    issue_t exp_rec;
    logic [`DEC_ROB_W:0] m_occ;
    logic [`DEC_ROB_W-1:0] m_head;
    logic [`DEC_ROB_W-1:0] m_tail;
    logic [`DEC_XLEN-1:0] m_pc [`DEC_ROB_DEPTH];
    logic [`DEC_REG_W-1:0] m_dst [`DEC_ROB_DEPTH];
    logic [`DEC_XLEN-1:0] m_val [`DEC_ROB_DEPTH];
    logic [`DEC_ROB_DEPTH-1:0] m_ld;
    logic [`DEC_ROB_DEPTH-1:0] m_st;
    logic [`DEC_ROB_DEPTH-1:0] m_done;
    logic [`DEC_NREGS-1:0] m_pend;
    logic [`DEC_ROB_W-1:0] m_prod [`DEC_NREGS];
    logic [`DEC_XLEN-1:0] m_rf [`DEC_NREGS];

    decode_stage dut_i (
        .i_clk          (clk),
        .i_reset        (reset),
        .i_if_valid     (if_valid),
        .i_if           (if_word),
        .o_if_readyn    (if_readyn),
        .i_issue_readyn (issue_readyn),
        .o_issue_valid  (issue_valid),
        .o_issue        (issue),
        .i_wb_en        (wb_en),
        .i_wb           (wb),
        .o_commit_valid (commit_valid),
        .o_commit_ready (commit_ready),
        .o_commit       (commit),
        .i_commit_en    (commit_en)
    );

    always #5 clk = ~clk;

    task stop_on_error(input string what);
        $display("error at %0t ns: %s", $time, what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task stop_on_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    // ------------------------------
    // reference decode and rename
    function automatic uop_t ref_decode(fetch_t w);
        uop_t u;
        logic [5:0] opc;
        opc    = w.insn[31:26];
        u      = '0;
        u.pc   = w.pc;
        u.imm  = {{(`DEC_XLEN-`DEC_IMM_W){w.insn[15]}}, w.insn[15:0]};
        u.op   = OP_NONE;
        u.pipe = PIPE_NONE;
        case (opc)
            `DEC_OPC_SPECIAL: begin
                case (w.insn[5:0])
                    `DEC_FN_ADDU: u.op = OP_ADD;
                    `DEC_FN_SUBU: u.op = OP_SUB;
                    `DEC_FN_AND:  u.op = OP_AND;
                    `DEC_FN_OR:   u.op = OP_OR;
                    `DEC_FN_SLT:  u.op = OP_SLT;
                    default: u.op = OP_NONE;
                endcase
            end
            `DEC_OPC_ADDIU: u.op = OP_ADD;
            `DEC_OPC_LW:    u.op = OP_LW;
            `DEC_OPC_SW:    u.op = OP_SW;
            `DEC_OPC_BEQ:   u.op = OP_BEQ;
            `DEC_OPC_BNE:   u.op = OP_BNE;
            default: u.op = OP_NONE;
        endcase
        case (u.op)
            OP_LW, OP_SW:   u.pipe = PIPE_MEM;
            OP_BEQ, OP_BNE: u.pipe = PIPE_BRU;
            OP_NONE:        u.pipe = PIPE_NONE;
            default:        u.pipe = PIPE_ALU;
        endcase
        if (u.op != OP_NONE) begin
            u.src0 = w.insn[25:21];             // rs is read by every supported kind
        end
        if (u.op != OP_NONE && opc == `DEC_OPC_SPECIAL) begin
            u.src1 = w.insn[20:16];
            u.dst  = w.insn[15:11];
        end else if (u.op == OP_LW || opc == `DEC_OPC_ADDIU) begin
            u.dst = w.insn[20:16];
        end else if (u.op != OP_NONE) begin
            u.src1 = w.insn[20:16];
        end
        u.load  = (u.op == OP_LW);
        u.store = (u.op == OP_SW);
        return u;
    endfunction

    function automatic logic src_ready(logic [`DEC_REG_W-1:0] r);
        logic [`DEC_ROB_W-1:0] t;
        t = m_prod[r];
        return !m_pend[r] || m_done[t] || (wb_en && wb.rob == t);
    endfunction

    function automatic logic [`DEC_XLEN-1:0] src_value(logic [`DEC_REG_W-1:0] r);
        logic [`DEC_ROB_W-1:0] t;
        t = m_prod[r];
        if (!m_pend[r]) begin
            return m_rf[r];
        end
        if (wb_en && wb.rob == t) begin
            return wb.value;                    // writeback in the rename cycle
        end
        return m_val[t];
    endfunction

    function automatic issue_t expect_issue(fetch_t w, logic [`DEC_ROB_W-1:0] tag);
        issue_t r;
        r            = '0;
        r.uop        = ref_decode(w);
        r.dst_rob    = tag;
        r.src0_rob   = m_prod[r.uop.src0];
        r.src0_ready = src_ready(r.uop.src0);
        r.src0_value = src_value(r.uop.src0);
        r.src1_rob   = m_prod[r.uop.src1];
        r.src1_ready = src_ready(r.uop.src1);
        r.src1_value = src_value(r.uop.src1);
        return r;
    endfunction

    // a waiting source is checked by tag, a ready one by value
    function automatic logic issue_matches(issue_t got, issue_t exp);
        logic ok;
        ok = (got.uop == exp.uop) && (got.dst_rob == exp.dst_rob)
            && (got.src0_ready == exp.src0_ready) && (got.src1_ready == exp.src1_ready);
        ok = ok && (exp.src0_ready ? got.src0_value == exp.src0_value
                                   : got.src0_rob == exp.src0_rob);
        ok = ok && (exp.src1_ready ? got.src1_value == exp.src1_value
                                   : got.src1_rob == exp.src1_rob);
        return ok;
    endfunction

    always @(posedge clk) begin : ref_model
        logic accept;
        logic alloc;
        uop_t u;
        accept = if_valid && !if_readyn;
        alloc  = pipe_v[1];
        u      = ref_decode(pipe_w[1]);
        if (reset) begin
            pipe_v <= '0;
            m_occ  <= '0;
            m_head <= '0;
            m_tail <= '0;
            m_done <= '0;
            m_pend <= '0;
            for (int r = 0; r < `DEC_NREGS; r++) begin
                m_rf[r]   <= '0;
                m_prod[r] <= '0;
            end
        end else begin
            pipe_v    <= {pipe_v[1:0], accept};
            pipe_w[0] <= if_word;
            pipe_w[1] <= pipe_w[0];
            if (commit_en) begin
                if (m_dst[m_head] != '0) begin
                    m_rf[m_dst[m_head]] <= m_val[m_head];
                    if (m_prod[m_dst[m_head]] == m_head) begin
                        m_pend[m_dst[m_head]] <= 1'b0;
                    end
                end
                m_head <= m_head + 1'b1;
            end
            if (alloc) begin
                exp_rec        <= expect_issue(pipe_w[1], m_tail);
                m_pc[m_tail]   <= u.pc;
                m_dst[m_tail]  <= u.dst;
                m_ld[m_tail]   <= u.load;
                m_st[m_tail]   <= u.store;
                m_done[m_tail] <= 1'b0;
                m_tail         <= m_tail + 1'b1;
                if (u.dst != '0) begin
                    m_pend[u.dst] <= 1'b1;     // a new producer beats the commit clear
                    m_prod[u.dst] <= m_tail;
                end
            end
            if (wb_en) begin
                m_done[wb.rob] <= 1'b1;
                m_val[wb.rob]  <= wb.value;
            end
            m_occ <= m_occ + 5'(alloc) - 5'(commit_en);
        end
    end

    // ------------------------------
    a_fetch_ready: assert property (@(posedge clk) disable iff (reset)
        if_readyn == (issue_readyn
            || ((`DEC_ROB_DEPTH - int'(m_occ)) <= (int'(pipe_v[0]) + int'(pipe_v[1])))))
        else stop_on_error("fetch ready level does not follow the ROB occupancy");

    a_issue_slot: assert property (@(posedge clk) disable iff (reset)
        issue_valid == pipe_v[2])
        else stop_on_error("issue pulse is not two edges after acceptance");

    a_issue_record: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> issue_matches(issue, exp_rec))
        else stop_on_error("issue record does not match the reference decode");

    a_head_state: assert property (@(posedge clk) disable iff (reset)
        (commit_valid == (m_occ != '0)) && (commit_ready == (m_occ != '0 && m_done[m_head])))
        else stop_on_error("ROB head valid or ready level is wrong");

    a_head_entry: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> (commit.rob == m_head && commit.pc == m_pc[m_head]
            && commit.dst == m_dst[m_head] && commit.load == m_ld[m_head]
            && commit.store == m_st[m_head]))
        else stop_on_error("ROB head entry is not the oldest allocation");

    a_head_value: assert property (@(posedge clk) disable iff (reset)
        commit_ready |-> commit.value == m_val[m_head])
        else stop_on_error("ROB head value differs from the writeback");

    // ------------------------------
    function automatic logic [31:0] rtype_word(logic [5:0] fn, logic [4:0] rs,
                                               logic [4:0] rt, logic [4:0] rd);
        return {`DEC_OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype_word(logic [5:0] opc, logic [4:0] rs,
                                               logic [4:0] rt, logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic logic [4:0] rnd_reg();
        return 5'($random(seed));
    endfunction

    function automatic logic [15:0] rnd_imm();
        return 16'($random(seed));
    endfunction

    task automatic send_word(input logic [31:0] insn);
        int waited;
        waited = 0;
        while (if_readyn) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 200) stop_on_timeout("fetch ready");
        end
        if_valid     = 1'b1;
        if_word.pc   = pc_next;
        if_word.insn = insn;
        pc_next      = pc_next + 32'd4;
        @(posedge clk);
        #1;
        if_valid = 1'b0;
    endtask

    task automatic writeback_tag(input logic [`DEC_ROB_W-1:0] tag, input logic [31:0] value);
        wb_en    = 1'b1;
        wb.rob   = tag;
        wb.value = value;
        @(posedge clk);
        #1;
        wb_en = 1'b0;
    endtask

    task automatic commit_head();
        int waited;
        waited = 0;
        while (!commit_ready) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 50) stop_on_timeout("the ROB head to be ready");
        end
        commit_en = 1'b1;
        @(posedge clk);
        #1;
        commit_en = 1'b0;
    endtask

    // write back youngest first, then retire everything in order
    task automatic drain_rob();
        int waited;
        int n;
        logic [`DEC_ROB_W-1:0] t;
        waited = 0;
        while (pipe_v != 3'b000) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 20) stop_on_timeout("the pipeline to empty");
        end
        n = int'(m_occ);
        for (int i = n - 1; i >= 0; i--) begin
            t = m_head + 4'(i);
            if (!m_done[t]) writeback_tag(t, $random(seed));
        end
        for (int i = 0; i < n; i++) begin
            commit_head();
        end
    endtask

    // ------------------------------
    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        if_valid     = 1'b0;
        if_word      = '0;
        issue_readyn = 1'b0;
        wb_en        = 1'b0;
        wb           = '0;
        commit_en    = 1'b0;
        seed         = 32'h8eb5_115c;
        pc_next      = 32'h0000_1000;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;

        // every supported kind, plus a jump which is not decoded
        send_word(itype_word(`DEC_OPC_ADDIU, 5'd0, 5'd7, rnd_imm()));
        send_word(rtype_word(`DEC_FN_ADDU, 5'd7, rnd_reg(), rnd_reg()));
        send_word(rtype_word(`DEC_FN_SUBU, rnd_reg(), rnd_reg(), rnd_reg()));
        send_word(rtype_word(`DEC_FN_AND, rnd_reg(), rnd_reg(), rnd_reg()));
        send_word(rtype_word(`DEC_FN_OR, rnd_reg(), rnd_reg(), rnd_reg()));
        send_word(rtype_word(`DEC_FN_SLT, rnd_reg(), rnd_reg(), rnd_reg()));
        send_word(itype_word(`DEC_OPC_LW, rnd_reg(), rnd_reg(), rnd_imm()));
        send_word(itype_word(`DEC_OPC_SW, rnd_reg(), rnd_reg(), rnd_imm()));
        send_word(itype_word(`DEC_OPC_BEQ, rnd_reg(), 5'd7, rnd_imm()));
        send_word(itype_word(`DEC_OPC_BNE, rnd_reg(), rnd_reg(), rnd_imm()));
        send_word(itype_word(6'h02, rnd_reg(), rnd_reg(), rnd_imm()));
        drain_rob();

        // readers of committed registers
        send_word(rtype_word(`DEC_FN_OR, 5'd7, 5'd0, 5'd8));
        send_word(rtype_word(`DEC_FN_ADDU, rnd_reg(), rnd_reg(), rnd_reg()));

        // the reader renames on the same edge as the producer's writeback
        send_word(itype_word(`DEC_OPC_ADDIU, rnd_reg(), 5'd9, rnd_imm()));
        send_word(rtype_word(`DEC_FN_OR, 5'd9, 5'd9, 5'd10));
        @(posedge clk);
        #1;
        writeback_tag(m_tail - 4'd1, $random(seed));
        drain_rob();

        // fill the ROB with no commits, then free one entry
        for (int k = 0; k < `DEC_ROB_DEPTH; k++) begin
            send_word(itype_word(`DEC_OPC_ADDIU, rnd_reg(), rnd_reg(), rnd_imm()));
        end
        repeat (4) @(posedge clk);
        #1;
        writeback_tag(m_head, $random(seed));
        commit_head();
        send_word(rtype_word(`DEC_FN_SLT, 5'd8, 5'd10, rnd_reg()));
        drain_rob();

        // downstream early warning with a word still in flight
        send_word(rtype_word(`DEC_FN_SUBU, 5'd10, 5'd8, 5'd11));
        issue_readyn = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        issue_readyn = 1'b0;
        @(posedge clk);
        #1;
        send_word(rtype_word(`DEC_FN_AND, 5'd11, rnd_reg(), rnd_reg()));
        send_word(itype_word(`DEC_OPC_LW, 5'd11, rnd_reg(), rnd_imm()));
        drain_rob();

        repeat (3) @(posedge clk);
        #1;
        $display("Regression passed");
        $finish;
    end

endmodule

// File: decode_stage.f
+incdir+design
design/decode_pkg.sv
design/decode_ctrl.sv
design/decode_insn.sv
design/decode_rob.sv
design/decode_rename.sv
design/decode_stage.sv
bench/decode_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the decode stage testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f decode_stage.f --top-module decode_stage_tb \
    -Mdir obj_dir -o decode_stage_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/decode_stage_sim > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0
